/* glb_bank.sv */
// ==========================================================
// contents are unknown after power-up; both read ports return
// data one cycle after the address, old data on a same-edge write
// ==========================================================
`timescale 1ns/1ps
`include "glb_config.svh"

module glb_bank (
    input  logic                               clk,

    // processor write port
    input  logic                               wr_en,
    input  logic [`GLB_STRB_WIDTH-1:0]         wr_strb,
    input  logic [`GLB_BANK_ADDR_WIDTH-1:0]    wr_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]         wr_data,

    // read ports
    input  logic [`GLB_BANK_ADDR_WIDTH-1:0]    proc_rd_addr,
    input  logic [`GLB_BANK_ADDR_WIDTH-1:0]    strm_rd_addr,
    output logic [`GLB_DATA_WIDTH-1:0]         proc_rd_data,
    output logic [`GLB_DATA_WIDTH-1:0]         strm_rd_data
);

localparam int DW    = `GLB_DATA_WIDTH;
localparam int SW    = `GLB_STRB_WIDTH;
localparam int WORDS = `GLB_BANK_WORDS;

logic [DW-1:0] mem [WORDS];

// byte-masked write
always_ff @(posedge clk) begin
    if (wr_en) begin
        for (int b = 0; b < SW; b++) begin
            if (wr_strb[b]) begin
                mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
            end
        end
    end
end

// two independent registered reads
always_ff @(posedge clk) begin
    proc_rd_data <= mem[proc_rd_addr];
    strm_rd_data <= mem[strm_rd_addr];
end

endmodule

/* glb_cfg_pkg.sv */
// ==========================================================
// configuration packet and per-tile register types
// ==========================================================
`include "glb_config.svh"

package glb_cfg_pkg;

    // request and response share one packet
    typedef struct packed {
        logic                              wr_en;
        logic                              rd_en;
        logic [`GLB_CFG_ADDR_WIDTH-1:0]    addr;
        logic [`GLB_CFG_DATA_WIDTH-1:0]    wr_data;
        logic [`GLB_CFG_DATA_WIDTH-1:0]    rd_data;
        logic                              rd_data_valid;
    } cfg_packet_t;

    // register index inside a tile
    typedef enum logic [`GLB_CFG_IDX_WIDTH-1:0] {
        REG_STRM_START_ADDR = 0,
        REG_STRM_NUM_WORDS  = 1
    } cfg_reg_e;

    // streaming setup seen by the reader
    typedef struct packed {
        logic [`GLB_BANK_ADDR_WIDTH-1:0]   start_addr;
        logic [`GLB_STRM_CNT_WIDTH-1:0]    num_words;
    } tile_cfg_t;

endpackage

/* glb_config.svh */
// ==========================================================
// sizes for a 4-tile build; address splits assume a power of two
// for both the tile count and the bank depth
// ==========================================================
`ifndef GLB_CONFIG_SVH
`define GLB_CONFIG_SVH

// chain length and bank size
`define GLB_NUM_TILES 4
`define GLB_BANK_WORDS 64

// bank and stream word
`define GLB_DATA_WIDTH 32
`define GLB_STRB_WIDTH 4

// processor address is tile select over word index
`define GLB_ADDR_WIDTH 8
`define GLB_TILE_SEL_WIDTH 2
`define GLB_BANK_ADDR_WIDTH 6

// configuration address is tile select over register index
`define GLB_CFG_ADDR_WIDTH 8
`define GLB_CFG_DATA_WIDTH 32
`define GLB_CFG_IDX_WIDTH 6
`define GLB_CFG_NUM_REGS 2

// word count needs one bit more than the bank address
`define GLB_STRM_CNT_WIDTH 7

`endif

/* glb_pkg.sv */
// ==========================================================
// processor packet and stream word types; no handshake fields,
// every enable or valid is a single-cycle qualifier
// ==========================================================
`include "glb_config.svh"

package glb_pkg;

    // processor write request
    typedef struct packed {
        logic                          wr_en;
        logic [`GLB_STRB_WIDTH-1:0]    wr_strb;
        logic [`GLB_ADDR_WIDTH-1:0]    wr_addr;
        logic [`GLB_DATA_WIDTH-1:0]    wr_data;
    } proc_wr_t;

    // processor read request
    typedef struct packed {
        logic                          rd_en;
        logic [`GLB_ADDR_WIDTH-1:0]    rd_addr;
    } proc_rdrq_t;

    // read response, filled in by the owning tile
    typedef struct packed {
        logic [`GLB_DATA_WIDTH-1:0]    rd_data;
        logic                          rd_data_valid;
    } proc_rdrs_t;

    // one hop of the processor chain
    typedef struct packed {
        proc_wr_t                      wr;
        proc_rdrq_t                    rdrq;
        proc_rdrs_t                    rdrs;
    } proc_packet_t;

    // glb to fabric stream word
    typedef struct packed {
        logic [`GLB_DATA_WIDTH-1:0]    data;
        logic                          valid;
    } strm_out_t;

endpackage

/* glb_strm_reader.sv */
// ==========================================================
// a start pulse during a block is dropped; registers are only
// sampled at the pulse, so later writes affect the next block
// ==========================================================
`timescale 1ns/1ps
`include "glb_config.svh"

module glb_strm_reader (
    input  logic                               clk,
    input  logic                               rst_n,

    input  logic                               strm_start_pulse,
    input  glb_cfg_pkg::tile_cfg_t             tile_cfg,

    // bank stream read port
    output logic [`GLB_BANK_ADDR_WIDTH-1:0]    strm_rd_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]         strm_rd_data,

    output glb_pkg::strm_out_t                 stream_g2f,
    output logic                               interrupt_pulse
);

localparam int BA = `GLB_BANK_ADDR_WIDTH;
localparam int CW = `GLB_STRM_CNT_WIDTH;

logic [BA-1:0] rd_addr_q;
logic [CW-1:0] remaining;
logic          busy;
logic          start;
logic          last_issue;
logic          issue_q;
logic          last_q;

// a block is in progress while words remain
assign busy       = (remaining != '0);
assign start      = strm_start_pulse && !busy && (tile_cfg.num_words != '0);
assign last_issue = busy && (remaining == CW'(1));

// address walk, wraps at the bank end
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        rd_addr_q <= '0;
        remaining <= '0;
    end else if (start) begin
        rd_addr_q <= tile_cfg.start_addr;
        remaining <= tile_cfg.num_words;
    end else if (busy) begin
        rd_addr_q <= rd_addr_q + BA'(1);
        remaining <= remaining - CW'(1);
    end
end

// bank data lands one cycle after the address
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        issue_q <= 1'b0;
        last_q  <= 1'b0;
    end else begin
        issue_q <= busy;
        last_q  <= last_issue;
    end
end

assign strm_rd_addr     = rd_addr_q;
assign stream_g2f.data  = strm_rd_data;
assign stream_g2f.valid = issue_q;
// interrupt rides with the last word
assign interrupt_pulse  = last_q;

endmodule

/* glb_tile.sv */
// ==========================================================
// every packet moves one tile east per clock with no back-pressure;
// only the tile named by the top address bits touches its bank
// ==========================================================
`timescale 1ns/1ps
`include "glb_config.svh"

module glb_tile #(
    parameter int unsigned TILE_ID = 0
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // processor chain
    input  glb_pkg::proc_packet_t      proc_west,
    output glb_pkg::proc_packet_t      proc_east,

    // configuration chain
    input  glb_cfg_pkg::cfg_packet_t   cfg_west,
    output glb_cfg_pkg::cfg_packet_t   cfg_east,

    // streaming
    input  logic                       strm_start_pulse,
    output glb_pkg::strm_out_t         stream_g2f,
    output logic                       interrupt_pulse
);

localparam int AW = `GLB_ADDR_WIDTH;
localparam int TS = `GLB_TILE_SEL_WIDTH;
localparam int BA = `GLB_BANK_ADDR_WIDTH;
localparam logic [TS-1:0] TILE_SEL = TS'(TILE_ID);

logic                          wr_hit;
logic                          rd_hit;
logic                          rd_hit_q;
glb_pkg::proc_packet_t         proc_q;
logic [`GLB_DATA_WIDTH-1:0]    proc_rd_data;
logic [`GLB_DATA_WIDTH-1:0]    strm_rd_data;
logic [BA-1:0]                 strm_rd_addr;
glb_cfg_pkg::tile_cfg_t        tile_cfg;

// address match on the tile field
assign wr_hit = proc_west.wr.wr_en && (proc_west.wr.wr_addr[AW-1 -: TS] == TILE_SEL);
assign rd_hit = proc_west.rdrq.rd_en && (proc_west.rdrq.rd_addr[AW-1 -: TS] == TILE_SEL);

glb_bank glb_bank_i (
    .clk          (clk),
    .wr_en        (wr_hit),
    .wr_strb      (proc_west.wr.wr_strb),
    .wr_addr      (proc_west.wr.wr_addr[BA-1:0]),
    .wr_data      (proc_west.wr.wr_data),
    .proc_rd_addr (proc_west.rdrq.rd_addr[BA-1:0]),
    .strm_rd_addr (strm_rd_addr),
    .proc_rd_data (proc_rd_data),
    .strm_rd_data (strm_rd_data)
);

// packet hop, in step with the bank read latency
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        proc_q   <= '0;
        rd_hit_q <= 1'b0;
    end else begin
        proc_q   <= proc_west;
        rd_hit_q <= rd_hit;
    end
end

// substitute bank data into the response of our own read
always_comb begin
    proc_east = proc_q;
    if (rd_hit_q) begin
        proc_east.rdrs.rd_data       = proc_rd_data;
        proc_east.rdrs.rd_data_valid = 1'b1;
    end
end

glb_tile_cfg #(
    .TILE_ID (TILE_ID)
) glb_tile_cfg_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg_west (cfg_west),
    .cfg_east (cfg_east),
    .tile_cfg (tile_cfg)
);

glb_strm_reader glb_strm_reader_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .strm_start_pulse (strm_start_pulse),
    .tile_cfg         (tile_cfg),
    .strm_rd_addr     (strm_rd_addr),
    .strm_rd_data     (strm_rd_data),
    .stream_g2f       (stream_g2f),
    .interrupt_pulse  (interrupt_pulse)
);

endmodule

/* glb_tile_cfg.sv */
// ==========================================================
// register reads return the value before a write in the same cycle;
// unmapped indices read as zero and ignore writes
// ==========================================================
`timescale 1ns/1ps
`include "glb_config.svh"

module glb_tile_cfg #(
    parameter int unsigned TILE_ID = 0
) (
    input  logic                       clk,
    input  logic                       rst_n,

    input  glb_cfg_pkg::cfg_packet_t   cfg_west,
    output glb_cfg_pkg::cfg_packet_t   cfg_east,
    output glb_cfg_pkg::tile_cfg_t     tile_cfg
);

localparam int AW = `GLB_CFG_ADDR_WIDTH;
localparam int DW = `GLB_CFG_DATA_WIDTH;
localparam int TS = `GLB_TILE_SEL_WIDTH;
localparam int IW = `GLB_CFG_IDX_WIDTH;
localparam int BA = `GLB_BANK_ADDR_WIDTH;
localparam int CW = `GLB_STRM_CNT_WIDTH;
localparam logic [TS-1:0] TILE_SEL = TS'(TILE_ID);

logic [IW-1:0] idx;
logic          hit;
logic          idx_mapped;
logic [DW-1:0] reg_rd_val;

assign idx        = cfg_west.addr[IW-1:0];
assign hit        = (cfg_west.addr[AW-1 -: TS] == TILE_SEL);
assign idx_mapped = (idx < IW'(`GLB_CFG_NUM_REGS));

// read mux, zero extended
always_comb begin
    reg_rd_val = '0;
    if (idx_mapped) begin
        case (glb_cfg_pkg::cfg_reg_e'(idx))
            glb_cfg_pkg::REG_STRM_START_ADDR: reg_rd_val = DW'(tile_cfg.start_addr);
            glb_cfg_pkg::REG_STRM_NUM_WORDS:  reg_rd_val = DW'(tile_cfg.num_words);
            default:                          reg_rd_val = '0;
        endcase
    end
end

// streaming registers
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        tile_cfg <= '0;
    end else if (hit && cfg_west.wr_en && idx_mapped) begin
        case (glb_cfg_pkg::cfg_reg_e'(idx))
            glb_cfg_pkg::REG_STRM_START_ADDR: tile_cfg.start_addr <= cfg_west.wr_data[BA-1:0];
            glb_cfg_pkg::REG_STRM_NUM_WORDS:  tile_cfg.num_words  <= cfg_west.wr_data[CW-1:0];
            default: ;
        endcase
    end
end

// one hop east; a read for this tile picks up its response here
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        cfg_east <= '0;
    end else begin
        cfg_east <= cfg_west;
        if (hit && cfg_west.rd_en) begin
            cfg_east.rd_data       <= reg_rd_val;
            cfg_east.rd_data_valid <= 1'b1;
        end
    end
end

endmodule

/* global_buffer.sv */
// ==========================================================
// responses leave the east end GLB_NUM_TILES cycles after entry;
// response fields of cfg_in are ignored
// ==========================================================
`timescale 1ns/1ps
`include "glb_config.svh"

module global_buffer (
    input  logic                                       clk,
    input  logic                                       rst_n,

    // processor
    input  glb_pkg::proc_wr_t                          proc_wr,
    input  glb_pkg::proc_rdrq_t                        proc_rdrq,
    output glb_pkg::proc_rdrs_t                        proc_rdrs,

    // configuration from the controller
    input  glb_cfg_pkg::cfg_packet_t                   cfg_in,
    output glb_cfg_pkg::cfg_packet_t                   cfg_out,

    // streaming
    input  logic [`GLB_NUM_TILES-1:0]                  strm_start_pulse,
    output glb_pkg::strm_out_t [`GLB_NUM_TILES-1:0]    stream_g2f,
    output logic [`GLB_NUM_TILES-1:0]                  interrupt_pulse
);

localparam int NT = `GLB_NUM_TILES;

// element i feeds tile i, element i+1 is its east side
glb_pkg::proc_packet_t     proc_chain [NT+1];
glb_cfg_pkg::cfg_packet_t  cfg_chain  [NT+1];

// west end, empty responses
assign proc_chain[0] = '{wr: proc_wr, rdrq: proc_rdrq, rdrs: '0};
assign cfg_chain[0]  = '{wr_en:         cfg_in.wr_en,
                         rd_en:         cfg_in.rd_en,
                         addr:          cfg_in.addr,
                         wr_data:       cfg_in.wr_data,
                         rd_data:       '0,
                         rd_data_valid: 1'b0};

for (genvar i = 0; i < NT; i++) begin : glb_tile_gen
    glb_tile #(
        .TILE_ID (i)
    ) glb_tile_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .proc_west        (proc_chain[i]),
        .proc_east        (proc_chain[i+1]),
        .cfg_west         (cfg_chain[i]),
        .cfg_east         (cfg_chain[i+1]),
        .strm_start_pulse (strm_start_pulse[i]),
        .stream_g2f       (stream_g2f[i]),
        .interrupt_pulse  (interrupt_pulse[i])
    );
end : glb_tile_gen

// east end
assign proc_rdrs = proc_chain[NT].rdrs;
assign cfg_out   = cfg_chain[NT];

endmodule

/* global_buffer_properties.sv */
// ==========================================================
// bound into global_buffer; checks hold only while rst_n is high
// ==========================================================
`timescale 1ns/1ps
`include "glb_config.svh"

module global_buffer_properties (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  glb_pkg::proc_rdrq_t                        proc_rdrq,
    input  glb_pkg::proc_rdrs_t                        proc_rdrs,
    input  glb_cfg_pkg::cfg_packet_t                   cfg_out,
    input  glb_pkg::strm_out_t [`GLB_NUM_TILES-1:0]    stream_g2f,
    input  logic [`GLB_NUM_TILES-1:0]                  interrupt_pulse
);

localparam int NT = `GLB_NUM_TILES;

// failed assertions so far
int unsigned   fail_count = 0;
logic [NT-1:0] strm_valid;

for (genvar i = 0; i < NT; i++) begin : valid_gen
    assign strm_valid[i] = stream_g2f[i].valid;
end : valid_gen

// response leaves the east end NT cycles after its request
assert property (@(posedge clk) disable iff (!rst_n)
    proc_rdrs.rd_data_valid == $past(proc_rdrq.rd_en, NT))
    else begin
        $error("read response not %0d cycles after its read request", NT);
        fail_count++;
    end

// interrupt only with a stream word of the same tile
assert property (@(posedge clk) disable iff (!rst_n)
    (interrupt_pulse & ~strm_valid) == '0)
    else begin
        $error("interrupt without stream valid on the same tile");
        fail_count++;
    end

// single-cycle pulse
assert property (@(posedge clk) disable iff (!rst_n)
    (interrupt_pulse & $past(interrupt_pulse)) == '0)
    else begin
        $error("interrupt pulse lasted two cycles");
        fail_count++;
    end

assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({proc_rdrs.rd_data_valid, cfg_out.rd_data_valid, strm_valid, interrupt_pulse}))
    else begin
        $error("output valid or interrupt is unknown");
        fail_count++;
    end

endmodule

bind global_buffer global_buffer_properties props_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .proc_rdrq       (proc_rdrq),
    .proc_rdrs       (proc_rdrs),
    .cfg_out         (cfg_out),
    .stream_g2f      (stream_g2f),
    .interrupt_pulse (interrupt_pulse)
);

/* run.sh */
#!/bin/sh
# compile and run the testbench with Verilator, result taken from the log
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module tb_global_buffer \
    -o sim_global_buffer \
    && ./obj_dir/sim_global_buffer +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log 2>/dev/null \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }

/* src.f */
+incdir+.
glb_pkg.sv
glb_cfg_pkg.sv
glb_bank.sv
glb_tile_cfg.sv
glb_strm_reader.sv
glb_tile.sv
global_buffer.sv
global_buffer_properties.sv
tb_global_buffer.sv

/* tb_global_buffer.sv */
// ==========================================================
// directed tests of the 4-tile chain; needs a simulator with timing
// support, inputs change 1 ns after each rising edge
// ==========================================================
`timescale 1ns/1ps
`include "glb_config.svh"

module tb_global_buffer;

localparam int NT           = `GLB_NUM_TILES;
localparam int DW           = `GLB_DATA_WIDTH;
localparam int AW           = `GLB_ADDR_WIDTH;
localparam int CAW          = `GLB_CFG_ADDR_WIDTH;
localparam int WORDS        = `GLB_BANK_WORDS;
localparam int REG_SPAN     = 1 << `GLB_CFG_IDX_WIDTH;
localparam int CLK_PERIOD   = 10;
localparam int RESET_CYCLES = 16;
localparam int WAIT_LIMIT   = 4 * NT + 8;
// worst case per test, in cycles
localparam int T_RDWR       = NT * (10 + WAIT_LIMIT);
localparam int T_STRB       = 2 * (4 + WAIT_LIMIT);
localparam int T_B2B        = 2 * NT + WAIT_LIMIT;
localparam int T_CFG        = NT * (2 + 3 * (2 + WAIT_LIMIT));
localparam int T_STRM       = 2 * WORDS + 3 * (WORDS + WAIT_LIMIT + 2 * NT + 4);
localparam int WATCHDOG_NS  = (RESET_CYCLES + 2 * (T_RDWR + T_STRB + T_B2B + T_CFG + T_STRM)
                              + 100) * CLK_PERIOD;

logic                          clk;
logic                          rst_n;
glb_pkg::proc_wr_t             proc_wr;
glb_pkg::proc_rdrq_t           proc_rdrq;
glb_pkg::proc_rdrs_t           proc_rdrs;
glb_cfg_pkg::cfg_packet_t      cfg_in;
glb_cfg_pkg::cfg_packet_t      cfg_out;
logic [NT-1:0]                 strm_start_pulse;
glb_pkg::strm_out_t [NT-1:0]   stream_g2f;
logic [NT-1:0]                 interrupt_pulse;

logic [31:0]   lfsr_state;
logic [DW-1:0] model [NT][WORDS];
int unsigned   cyc = 0;
int unsigned   errors = 0;
int unsigned   test_mark = 0;
int unsigned   tests_run = 0;
int unsigned   total_errors;
// outstanding reads: expected data and the edge that samples it
logic [DW-1:0] exp_data_q [$];
int unsigned   exp_edge_q [$];

global_buffer dut_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .proc_wr          (proc_wr),
    .proc_rdrq        (proc_rdrq),
    .proc_rdrs        (proc_rdrs),
    .cfg_in           (cfg_in),
    .cfg_out          (cfg_out),
    .strm_start_pulse (strm_start_pulse),
    .stream_g2f       (stream_g2f),
    .interrupt_pulse  (interrupt_pulse)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

always @(posedge clk) cyc <= cyc + 1;

initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
    $display("tests failed");
    $finish;
end

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic draw_word(output logic [DW-1:0] w);
    for (int i = 0; i < DW; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        w[i] = lfsr_state[0];
    end
endtask

task automatic report_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
endtask

task automatic check_rdrs(input string name, input glb_pkg::proc_rdrs_t exp,
                          input glb_pkg::proc_rdrs_t act);
    if (act.rd_data_valid !== exp.rd_data_valid ||
        (exp.rd_data_valid && act.rd_data !== exp.rd_data)) begin
        $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_cfg(input string name, input logic [`GLB_CFG_DATA_WIDTH-1:0] exp,
                         input logic [`GLB_CFG_DATA_WIDTH-1:0] act);
    if (act !== exp) begin
        $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_strm(input string name, input glb_pkg::strm_out_t exp,
                          input glb_pkg::strm_out_t act);
    if (act.valid !== exp.valid || (exp.valid && act.data !== exp.data)) begin
        $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
        errors++;
    end
endtask

task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

task automatic end_test(input string name);
    tests_run++;
    $display("test %s finished with %0d errors", name, errors - test_mark);
    test_mark = errors;
endtask

// read responses are matched in request order
always @(negedge clk) begin
    if (rst_n && proc_rdrs.rd_data_valid === 1'b1) begin
        if (exp_data_q.size() == 0) begin
            report_error("read response with no read outstanding");
        end else begin
            if (exp_edge_q[0] != cyc + 1) begin
                report_error("read response arrived at the wrong cycle");
            end
            check_rdrs("proc_rdrs", '{rd_data: exp_data_q[0], rd_data_valid: 1'b1}, proc_rdrs);
            void'(exp_data_q.pop_front());
            void'(exp_edge_q.pop_front());
        end
    end else if (rst_n && exp_edge_q.size() != 0 && exp_edge_q[0] <= cyc + 1) begin
        report_error("read response missing");
        void'(exp_data_q.pop_front());
        void'(exp_edge_q.pop_front());
    end
end

task automatic proc_write(input int t, input int w, input logic [3:0] strb,
                          input logic [DW-1:0] data);
    proc_wr = '{wr_en: 1'b1, wr_strb: strb, wr_addr: AW'(t * WORDS + w), wr_data: data};
    for (int b = 0; b < 4; b++) begin
        if (strb[b]) model[t][w][b*8 +: 8] = data[b*8 +: 8];
    end
    next_cycle();
    proc_wr = '0;
endtask

task automatic proc_read(input int t, input int w);
    proc_rdrq = '{rd_en: 1'b1, rd_addr: AW'(t * WORDS + w)};
    exp_data_q.push_back(model[t][w]);
    exp_edge_q.push_back(cyc + 1 + NT);
    next_cycle();
    proc_rdrq = '0;
endtask

task automatic wait_reads();
    int waited = 0;
    while (exp_data_q.size() != 0 && waited < WAIT_LIMIT) begin
        next_cycle();
        waited++;
    end
    if (exp_data_q.size() != 0) begin
        report_error("timed out waiting for read responses");
        exp_data_q.delete();
        exp_edge_q.delete();
    end
endtask

task automatic cfg_write(input int t, input int idx, input logic [31:0] data);
    cfg_in = '{wr_en: 1'b1, rd_en: 1'b0, addr: CAW'(t * REG_SPAN + idx), wr_data: data,
               rd_data: '0, rd_data_valid: 1'b0};
    next_cycle();
    cfg_in = '0;
endtask

task automatic cfg_read_check(input int t, input int idx, input logic [31:0] exp);
    int unsigned issue_edge;
    int          waited;
    cfg_in = '{wr_en: 1'b0, rd_en: 1'b1, addr: CAW'(t * REG_SPAN + idx), wr_data: '0,
               rd_data: '0, rd_data_valid: 1'b0};
    issue_edge = cyc + 1;
    next_cycle();
    cfg_in = '0;
    waited = 0;
    while (cfg_out.rd_data_valid !== 1'b1 && waited < WAIT_LIMIT) begin
        next_cycle();
        waited++;
    end
    if (cfg_out.rd_data_valid !== 1'b1) begin
        report_error("no configuration read response");
    end else begin
        if (cyc + 1 - issue_edge != NT) report_error("configuration response at wrong cycle");
        check_cfg($sformatf("cfg_out.rd_data tile %0d reg %0d", t, idx), exp, cfg_out.rd_data);
    end
    next_cycle();
endtask

task automatic run_stream(input int t, input int start, input int count);
    int unsigned start_edge;
    int          got;
    cfg_write(t, glb_cfg_pkg::REG_STRM_START_ADDR, start);
    cfg_write(t, glb_cfg_pkg::REG_STRM_NUM_WORDS, count);
    repeat (NT) next_cycle();
    strm_start_pulse[t] = 1'b1;
    start_edge = cyc + 1;
    next_cycle();
    strm_start_pulse = '0;
    got = 0;
    for (int c = 0; c < count + WAIT_LIMIT; c++) begin
        for (int i = 0; i < NT; i++) begin
            if (i != t) begin
                check_bit($sformatf("stream_g2f[%0d].valid", i), 1'b0, stream_g2f[i].valid);
                check_bit($sformatf("interrupt_pulse[%0d]", i), 1'b0, interrupt_pulse[i]);
            end
        end
        if (stream_g2f[t].valid !== 1'b1) begin
            check_bit($sformatf("interrupt_pulse[%0d]", t), 1'b0, interrupt_pulse[t]);
        end else if (got >= count) begin
            report_error("stream word beyond the block length");
        end else begin
            if (cyc + 1 != start_edge + 2 + got) report_error("stream word at the wrong cycle");
            check_strm($sformatf("stream_g2f[%0d]", t),
                       '{data: model[t][(start + got) % WORDS], valid: 1'b1}, stream_g2f[t]);
            check_bit($sformatf("interrupt_pulse[%0d]", t), got == count - 1,
                      interrupt_pulse[t]);
            got++;
        end
        next_cycle();
    end
    if (got != count) report_error($sformatf("tile %0d streamed %0d words", t, got));
endtask

initial begin
    logic [DW-1:0] d;
    lfsr_state       = 32'hdb43_8e79;
    rst_n            = 1'b0;
    proc_wr          = '0;
    proc_rdrq        = '0;
    cfg_in           = '0;
    strm_start_pulse = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();

    // outputs quiet after reset
    check_rdrs("proc_rdrs", '0, proc_rdrs);
    check_bit("cfg_out.rd_data_valid", 1'b0, cfg_out.rd_data_valid);
    for (int i = 0; i < NT; i++) begin
        check_strm($sformatf("stream_g2f[%0d]", i), '0, stream_g2f[i]);
        check_bit($sformatf("interrupt_pulse[%0d]", i), 1'b0, interrupt_pulse[i]);
    end
    end_test("reset_state");

    // first address of each tile is read right after its write
    for (int t = 0; t < NT; t++) begin
        for (int k = 0; k < 4; k++) begin
            draw_word(d);
            proc_write(t, (k * 17 + t * 5) % WORDS, 4'hf, d);
            if (k == 0) proc_read(t, t * 5);
        end
        for (int k = 0; k < 4; k++) proc_read(t, (k * 17 + t * 5) % WORDS);
        wait_reads();
    end
    end_test("write_read");

    // both targets were fully written above
    draw_word(d);
    proc_write(1, 22, 4'b0101, d);
    proc_read(1, 22);
    draw_word(d);
    proc_write(3, 32, 4'b1000, d);
    proc_read(3, 32);
    wait_reads();
    end_test("partial_strobe");

    for (int i = 0; i < 2 * NT; i++) proc_read(i % NT, (i % NT) * 5);
    wait_reads();
    end_test("back_to_back");

    // registers keep only their own width; index 2 and up is unmapped
    for (int t = 0; t < NT; t++) begin
        logic [DW-1:0] sa;
        logic [DW-1:0] nw;
        draw_word(sa);
        draw_word(nw);
        cfg_write(t, glb_cfg_pkg::REG_STRM_START_ADDR, sa);
        cfg_write(t, glb_cfg_pkg::REG_STRM_NUM_WORDS, nw);
        cfg_read_check(t, glb_cfg_pkg::REG_STRM_START_ADDR, sa & 32'h3f);
        cfg_read_check(t, glb_cfg_pkg::REG_STRM_NUM_WORDS, nw & 32'h7f);
        cfg_read_check(t, 2 + t, 32'h0);
    end
    end_test("cfg_regs");

    for (int t = 1; t <= 2; t++) begin
        for (int w = 0; w < WORDS; w++) begin
            draw_word(d);
            proc_write(t, w, 4'hf, d);
        end
    end
    run_stream(1, 3, 12);
    // this block wraps past the last word
    run_stream(2, 58, 12);
    run_stream(3, 0, 0);
    end_test("stream");

    repeat (NT + 2) next_cycle();
    total_errors = errors + dut_i.props_i.fail_count;
    $display("%0d tests run, %0d errors", tests_run, total_errors);
    if (total_errors == 0) begin
        $display("all tests passed");
    end else begin
        $display("tests failed");
    end
    $finish;
end

endmodule
